//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run rvCoreTb"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module rvCoreTb -Mdir obj_dir
	./obj_dir/VrvCoreTb

clean:
	rm -rf obj_dir

//--- flist.f
hdl/rvPkg.sv
hdl/controlIf.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/loadStoreUnit.sv
hdl/controller.sv
hdl/csrFile.sv
hdl/datapath.sv
hdl/rvCore.sv
verification/rvCoreChecker_checker.sv
verification/rvCoreTb.sv

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu import rvPkg::*; (
    input  word_t op1,
    input  word_t op2,
    input  aluOpE op,
    output word_t res,
    output logic  zero
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (op)
            aluAdd:  res = op1 + op2;
            aluSub:  res = op1 - op2;
            aluSll:  res = op1 << shamt;
            aluSlt:  res = {31'b0, $signed(op1) < $signed(op2)};
            aluSltu: res = {31'b0, op1 < op2};
            aluXor:  res = op1 ^ op2;
            aluSrl:  res = op1 >> shamt;
            aluSra:  res = word_t'($signed(op1) >>> shamt);
            aluOr:   res = op1 | op2;
            aluAnd:  res = op1 & op2;
            aluPass: res = op2;
            default: res = '0;
        endcase
    end

    assign zero = (res == '0);

endmodule

//--- hdl/controlIf.sv
`timescale 1ns/10ps

interface controlIf import rvPkg::*; ();

    aluOpE   aluOp;
    aluSrc1E aluSrc1;
    aluSrc2E aluSrc2;
    wbSelE   wbSel;
    logic    regWE;
    logic    memWE;
    memSizeE memSize;
    logic    loadUnsigned;
    pcSelE   pcSel;
    csrOpE   csrOp;
    logic    isEcall;
    logic    isMret;

    modport ctrl (
        output aluOp, aluSrc1, aluSrc2, wbSel, regWE, memWE, memSize,
               loadUnsigned, pcSel, csrOp, isEcall, isMret
    );

    modport dp (
        input aluOp, aluSrc1, aluSrc2, wbSel, regWE, memSize,
              loadUnsigned, pcSel, isMret
    );

    modport csr (
        input csrOp, isEcall, isMret
    );

endinterface

//--- hdl/controller.sv
`timescale 1ns/10ps

module controller import rvPkg::*; (
    input  word_t  instr,
    input  logic   aluZero,
    input  logic   aluLsb,
    controlIf.ctrl ctl
);

    logic [2:0] funct3;
    logic       funct7b5;
    aluOpE      arithOp;
    aluOpE      cmpOp;
    logic       branchTaken;

    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // funct3 decode shared by register and immediate arithmetic
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (funct7b5 && instr[6:0] == opReg) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    // beq/bne use sub and the zero flag, the rest use slt or sltu
    assign cmpOp = funct3[2] ? (funct3[1] ? aluSltu : aluSlt) : aluSub;

    always_comb begin
        case (funct3)
            3'b000:         branchTaken = aluZero;
            3'b001:         branchTaken = !aluZero;
            3'b100, 3'b110: branchTaken = aluLsb;
            3'b101, 3'b111: branchTaken = !aluLsb;
            default:        branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        ctl.aluOp        = aluAdd;
        ctl.aluSrc1      = src1Rs1;
        ctl.aluSrc2      = src2Rs2;
        ctl.wbSel        = wbAlu;
        ctl.regWE        = 1'b0;
        ctl.memWE        = 1'b0;
        ctl.memSize      = sizeWord;
        ctl.loadUnsigned = funct3[2];
        ctl.pcSel        = pcSeq;
        ctl.csrOp        = csrNone;
        ctl.isEcall      = 1'b0;
        ctl.isMret       = 1'b0;
        case (instr[6:0])
            opLui: begin
                ctl.aluSrc1 = src1Zero;
                ctl.aluSrc2 = src2Imm;
                ctl.regWE   = 1'b1;
            end
            opAuipc: begin
                ctl.aluSrc1 = src1Pc;
                ctl.aluSrc2 = src2Imm;
                ctl.regWE   = 1'b1;
            end
            opJal: begin
                ctl.wbSel = wbPc4;
                ctl.regWE = 1'b1;
                ctl.pcSel = pcTarget;
            end
            opJalr: begin
                ctl.aluSrc2 = src2Imm;
                ctl.wbSel   = wbPc4;
                ctl.regWE   = 1'b1;
                ctl.pcSel   = pcJalr;
            end
            opBranch: begin
                ctl.aluOp = cmpOp;
                ctl.pcSel = branchTaken ? pcTarget : pcSeq;
            end
            opLoad: begin
                ctl.aluSrc2 = src2Imm;
                ctl.wbSel   = wbLoad;
                ctl.regWE   = 1'b1;
                ctl.memSize = memSizeE'(funct3[1:0]);
            end
            opStore: begin
                ctl.aluSrc2 = src2Imm;
                ctl.memWE   = 1'b1;
                ctl.memSize = memSizeE'(funct3[1:0]);
            end
            opImm: begin
                ctl.aluOp   = arithOp;
                ctl.aluSrc2 = src2Imm;
                ctl.regWE   = 1'b1;
            end
            opReg: begin
                ctl.aluOp = arithOp;
                ctl.regWE = 1'b1;
            end
            opSystem: begin
                if (funct3 == 3'b000) begin
                    ctl.isEcall = (instr[31:20] == 12'h000);
                    ctl.isMret  = (instr[31:20] == 12'h302);
                end else if (!funct3[2]) begin
                    // register forms only, immediate forms fall through as no-ops
                    ctl.csrOp   = csrOpE'(funct3[1:0]);
                    ctl.aluOp   = aluPass;
                    ctl.aluSrc2 = src2Csr;
                    ctl.wbSel   = wbCsr;
                    ctl.regWE   = 1'b1;
                end
            end
            default: begin
                // unknown opcode just advances
            end
        endcase
    end

endmodule

//--- hdl/csrFile.sv
`timescale 1ns/10ps

module csrFile import rvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    controlIf.csr       ctl,
    input  logic [11:0] csrAddr,
    input  word_t       csrWrData,
    input  word_t       pc,
    input  word_t       pcNext,
    input  logic        irq,
    output word_t       csrRdData,
    output logic        trapTaken,
    output word_t       trapTarget,
    output word_t       mepc
);

    logic  mie;
    word_t mtvec;
    word_t mcause;
    word_t csrNewVal;
    word_t cause;
    word_t tvecBase;
    logic  irqTaken;
    logic  csrWE;

    assign irqTaken  = irq && mie;
    assign trapTaken = irqTaken || ctl.isEcall;
    assign cause     = irqTaken ? causeExtIrq : causeEcall;
    assign csrWE     = (ctl.csrOp != csrNone) && !trapTaken;

    always_comb begin
        case (csrAddr)
            csrMstatus: csrRdData = {28'b0, mie, 3'b000};
            csrMtvec:   csrRdData = mtvec;
            csrMepc:    csrRdData = mepc;
            csrMcause:  csrRdData = mcause;
            default:    csrRdData = '0;
        endcase
    end

    always_comb begin
        case (ctl.csrOp)
            csrSet:   csrNewVal = csrRdData | csrWrData;
            csrClear: csrNewVal = csrRdData & ~csrWrData;
            default:  csrNewVal = csrWrData;
        endcase
    end

    // vectored mode only offsets interrupts
    assign tvecBase   = {mtvec[31:2], 2'b00};
    assign trapTarget = (mtvec[0] && irqTaken) ? tvecBase + {cause[29:0], 2'b00} : tvecBase;

    always_ff @(posedge clk) begin
        if (reset) begin
            mie    <= 1'b0;
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else if (trapTaken) begin
            // an interrupted mret resumes at its own target
            mepc   <= (irqTaken && ctl.isMret) ? pcNext : pc;
            mcause <= cause;
            mie    <= 1'b0;
        end else if (ctl.isMret) begin
            mie <= 1'b1;
        end else if (csrWE) begin
            case (csrAddr)
                csrMstatus: mie    <= csrNewVal[3];
                csrMtvec:   mtvec  <= csrNewVal;
                csrMepc:    mepc   <= csrNewVal;
                csrMcause:  mcause <= csrNewVal;
                default:    mie    <= mie;
            endcase
        end
    end

endmodule

//--- hdl/datapath.sv
`timescale 1ns/10ps

module datapath import rvPkg::*; #(
    parameter word_t resetPc = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instr,
    controlIf.dp       ctl,
    input  word_t      csrRdData,
    input  logic       trapTaken,
    input  word_t      trapTarget,
    input  word_t      mepc,
    input  word_t      memRdData,
    output word_t      pc,
    output word_t      pcNext,
    output word_t      rs1Data,
    output logic       aluZero,
    output logic       aluLsb,
    output word_t      memAddr,
    output word_t      memWrData,
    output logic [3:0] memMask
);

    word_t imm;
    word_t rs2Data;
    word_t op1;
    word_t op2;
    word_t aluRes;
    word_t loadData;
    word_t wbData;
    word_t pcPlus4;
    word_t pcSelected;

    always_comb begin
        case (instr[6:0])
            opStore:        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:       imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            opLui, opAuipc: imm = {instr[31:12], 12'b0};
            opJal:          imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            default:        imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    registerFile regFile (
        .clk(clk),
        .rdAddr1(instr[19:15]),
        .rdAddr2(instr[24:20]),
        .wrAddr(instr[11:7]),
        .wrData(wbData),
        .wrEn(ctl.regWE && !trapTaken),
        .rdData1(rs1Data),
        .rdData2(rs2Data)
    );

    always_comb begin
        case (ctl.aluSrc1)
            src1Pc:   op1 = pc;
            src1Zero: op1 = '0;
            default:  op1 = rs1Data;
        endcase
    end

    always_comb begin
        case (ctl.aluSrc2)
            src2Imm: op2 = imm;
            src2Csr: op2 = csrRdData;
            default: op2 = rs2Data;
        endcase
    end

    alu aluInst (
        .op1(op1),
        .op2(op2),
        .op(ctl.aluOp),
        .res(aluRes),
        .zero(aluZero)
    );

    assign aluLsb  = aluRes[0];
    assign memAddr = aluRes;

    loadStoreUnit lsu (
        .addrLow(aluRes[1:0]),
        .size(ctl.memSize),
        .loadUnsigned(ctl.loadUnsigned),
        .storeData(rs2Data),
        .memRdData(memRdData),
        .memWrData(memWrData),
        .memMask(memMask),
        .loadData(loadData)
    );

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctl.wbSel)
            wbLoad:  wbData = loadData;
            wbPc4:   wbData = pcPlus4;
            wbCsr:   wbData = csrRdData;
            default: wbData = aluRes;
        endcase
    end

    always_comb begin
        case (ctl.pcSel)
            pcTarget: pcSelected = pc + imm;
            pcJalr:   pcSelected = {aluRes[31:1], 1'b0};
            default:  pcSelected = pcPlus4;
        endcase
    end

    // next PC without a trap, the trap target overrides it below
    assign pcNext = ctl.isMret ? mepc : pcSelected;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= trapTaken ? trapTarget : pcNext;
        end
    end

endmodule

//--- hdl/loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit import rvPkg::*; (
    input  logic [1:0] addrLow,
    input  memSizeE    size,
    input  logic       loadUnsigned,
    input  word_t      storeData,
    input  word_t      memRdData,
    output word_t      memWrData,
    output logic [3:0] memMask,
    output word_t      loadData
);

    logic [4:0] laneShift;
    logic [3:0] baseMask;
    word_t      rdShifted;
    logic [7:0] loadByte;
    logic [15:0] loadHalf;

    assign laneShift = {addrLow, 3'b000};

    always_comb begin
        case (size)
            sizeByte: baseMask = 4'b0001;
            sizeHalf: baseMask = 4'b0011;
            default:  baseMask = 4'b1111;
        endcase
    end

    // store side, data moved up to the addressed lane
    assign memWrData = storeData << laneShift;
    assign memMask   = baseMask << addrLow;

    // load side, addressed lane moved down to bit 0
    assign rdShifted = memRdData >> laneShift;
    assign loadByte  = rdShifted[7:0];
    assign loadHalf  = rdShifted[15:0];

    always_comb begin
        case (size)
            sizeByte: begin
                loadData = loadUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
            end
            sizeHalf: begin
                loadData = loadUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
            end
            default: begin
                loadData = memRdData;
            end
        endcase
    end

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/10ps

module registerFile import rvPkg::*; (
    input  logic       clk,
    input  logic [4:0] rdAddr1,
    input  logic [4:0] rdAddr2,
    input  logic [4:0] wrAddr,
    input  word_t      wrData,
    input  logic       wrEn,
    output word_t      rdData1,
    output word_t      rdData2
);

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 always reads zero
    assign rdData1 = (rdAddr1 == 5'd0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == 5'd0) ? '0 : regs[rdAddr2];

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/10ps

module rvCore import rvPkg::*; #(
    parameter word_t resetPc = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instr,
    output word_t      pc,
    output word_t      memAddr,
    output word_t      memWrData,
    input  word_t      memRdData,
    output logic       memWE,
    output logic [3:0] memMask,
    input  logic       irq
);

    logic  aluZero;
    logic  aluLsb;
    word_t csrRdData;
    logic  trapTaken;
    word_t trapTarget;
    word_t mepc;
    word_t pcNext;
    word_t rs1Data;

    controlIf ctl ();

    controller ctrlInst (
        .instr(instr),
        .aluZero(aluZero),
        .aluLsb(aluLsb),
        .ctl(ctl)
    );

    datapath #(
        .resetPc(resetPc)
    ) dpInst (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .ctl(ctl),
        .csrRdData(csrRdData),
        .trapTaken(trapTaken),
        .trapTarget(trapTarget),
        .mepc(mepc),
        .memRdData(memRdData),
        .pc(pc),
        .pcNext(pcNext),
        .rs1Data(rs1Data),
        .aluZero(aluZero),
        .aluLsb(aluLsb),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memMask(memMask)
    );

    csrFile csrInst (
        .clk(clk),
        .reset(reset),
        .ctl(ctl),
        .csrAddr(instr[31:20]),
        .csrWrData(rs1Data),
        .pc(pc),
        .pcNext(pcNext),
        .irq(irq),
        .csrRdData(csrRdData),
        .trapTaken(trapTaken),
        .trapTarget(trapTarget),
        .mepc(mepc)
    );

    // an interrupted store must not reach memory
    assign memWE = ctl.memWE && !trapTaken;

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

    typedef logic [31:0] word_t;

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opSystem = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPass
    } aluOpE;

    typedef enum logic [1:0] {src1Rs1, src1Pc, src1Zero} aluSrc1E;
    typedef enum logic [1:0] {src2Rs2, src2Imm, src2Csr} aluSrc2E;
    typedef enum logic [1:0] {wbAlu, wbLoad, wbPc4, wbCsr} wbSelE;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSizeE;

    // matches funct3[1:0] of csrrw, csrrs, csrrc
    typedef enum logic [1:0] {csrNone, csrWrite, csrSet, csrClear} csrOpE;

    typedef enum logic [1:0] {pcSeq, pcTarget, pcJalr} pcSelE;

    localparam logic [11:0] csrMstatus = 12'h300;
    localparam logic [11:0] csrMtvec   = 12'h305;
    localparam logic [11:0] csrMepc    = 12'h341;
    localparam logic [11:0] csrMcause  = 12'h342;

    localparam word_t causeEcall  = 32'd11;
    localparam word_t causeExtIrq = 32'h8000_000b;

endpackage

//--- verification/rvCoreChecker_checker.sv
`timescale 1ns/10ps

module rvCoreChecker import rvPkg::*; (
    input logic       clk,
    input logic       reset,
    input word_t      pc,
    input logic       memWE,
    input logic [3:0] memMask
);

    // a store touches an aligned byte, half or word
    storeHasMask: assert property (
        @(posedge clk) disable iff (reset)
            memWE |-> (memMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                       4'b0011, 4'b1100, 4'b1111})
    ) else $error("memWE high with an empty or misaligned memMask");

    pcAligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("pc is not word aligned");

    // first cycle out of reset
    noStoreAfterReset: assert property (
        @(posedge clk) $fell(reset) |-> !memWE
    ) else $error("memWE high in the cycle after reset");

endmodule

//--- verification/rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb import rvPkg::*; ();

    localparam word_t resetPc    = 32'h0;
    localparam word_t markerAddr = 32'h7f0;

    logic       clk;
    logic       reset;
    logic       irq;
    word_t      instr;
    word_t      pc;
    word_t      memAddr;
    word_t      memWrData;
    word_t      memRdData;
    logic       memWE;
    logic [3:0] memMask;

    word_t      imem [0:255];
    word_t      dmem [0:255];
    word_t      expAddr [0:63];
    word_t      expData [0:63];
    logic [3:0] expMask [0:63];
    int         expCount;
    int         storeIdx;
    int         wp;
    int         slot;
    int         cycles;
    int         limit;
    word_t      lfsrState;
    logic [3:0] irqDelay;

    rvCore #(
        .resetPc(resetPc)
    ) uut (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pc(pc),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memRdData(memRdData),
        .memWE(memWE),
        .memMask(memMask),
        .irq(irq)
    );

    bind rvCore rvCoreChecker assertInst (
        .clk(clk),
        .reset(reset),
        .pc(pc),
        .memWE(memWE),
        .memMask(memMask)
    );

    assign instr     = imem[pc[9:2]];
    assign memRdData = dmem[memAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction encoders, RV32I formats
    function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t encI(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t encS(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic word_t encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t encU(int imm, int rd, int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic word_t lfsrStep(word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t laneBits(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic emit(word_t w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic addExpect(int addr, int data, int mask);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expMask[expCount] = mask[3:0];
        expCount++;
    endtask

    // word store of a register into the next result slot
    task automatic swCheck(int rs2, int data);
        emit(encS(slot * 4, rs2, 10, 2));
        addExpect(32'h400 + slot * 4, data, 'hf);
        slot++;
    endtask

    task automatic valueCheck(word_t w, int rd, int data);
        emit(w);
        swCheck(rd, data);
    endtask

    task automatic memCheck(word_t w, int addr, int data, int mask);
        emit(w);
        addExpect(addr, data, mask);
    endtask

    // must never reach memory
    task automatic badStore();
        emit(encS('h3fc, 2, 10, 2));
    endtask

    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = encI(i, 0, 0, 0, 'h13);
            dmem[i] = (i * 32'h0101_0101) ^ 32'h5a3c_96e1;
        end
    endtask

    task automatic buildProgram();
        int linkPc;
        int basePc;
        int mainWords;
        int irqPc;
        wp       = 0;
        slot     = 0;
        expCount = 0;
        emit(encI('h201, 0, 0, 1, 'h13));
        emit(encI('h305, 1, 1, 0, 'h73));
        emit(encI('h400, 0, 0, 10, 'h13));
        emit(encI(-7, 0, 0, 2, 'h13));
        emit(encI(3, 0, 0, 3, 'h13));
        // x2 = -7, x3 = 3
        valueCheck(encR('h00, 3, 2, 0, 4), 4, 32'hfffffffc);
        valueCheck(encR('h20, 3, 2, 0, 4), 4, 32'hfffffff6);
        valueCheck(encR('h00, 3, 3, 1, 4), 4, 32'h18);
        valueCheck(encR('h00, 3, 2, 2, 4), 4, 1);
        valueCheck(encR('h00, 3, 2, 3, 4), 4, 0);
        valueCheck(encR('h00, 3, 2, 4, 4), 4, 32'hfffffffa);
        valueCheck(encR('h00, 3, 2, 5, 4), 4, 32'h1fffffff);
        valueCheck(encR('h20, 3, 2, 5, 4), 4, 32'hffffffff);
        valueCheck(encR('h00, 3, 2, 6, 4), 4, 32'hfffffffb);
        valueCheck(encR('h00, 3, 2, 7, 4), 4, 1);
        valueCheck(encI('h00f, 2, 4, 4, 'h13), 4, 32'hfffffff6);
        valueCheck(encI('h401, 2, 5, 4, 'h13), 4, 32'hfffffffc);
        valueCheck(encI(5, 3, 3, 4, 'h13), 4, 1);
        valueCheck(encI(4, 3, 1, 4, 'h13), 4, 32'h30);
        valueCheck(encU('h12345, 4, 'h37), 4, 32'h12345000);
        valueCheck(encU(1, 4, 'h17), 4, wp * 4 + 32'h1000);
        // x5 = 818283f4, byte and half lanes
        emit(encU('h81828, 5, 'h37));
        emit(encI('h3f4, 5, 0, 5, 'h13));
        for (int k = 0; k < 4; k++) begin
            memCheck(encS('h100 + k, 5, 10, 0), 32'h500 + k, 32'hf4 << (8 * k), 1 << k);
        end
        memCheck(encS('h110, 5, 10, 1), 32'h510, 32'h83f4, 'h3);
        memCheck(encS('h112, 5, 10, 1), 32'h512, 32'h83f40000, 'hc);
        valueCheck(encI('h101, 10, 0, 6, 'h03), 6, 32'hfffffff4);
        valueCheck(encI('h103, 10, 4, 6, 'h03), 6, 32'hf4);
        valueCheck(encI('h112, 10, 1, 6, 'h03), 6, 32'hffff83f4);
        valueCheck(encI('h110, 10, 5, 6, 'h03), 6, 32'h83f4);
        valueCheck(encI('h110, 10, 2, 6, 'h03), 6, 32'h83f483f4);
        // branches jump over the next store when taken
        emit(encB(8, 3, 2, 0));
        swCheck(3, 3);
        emit(encB(8, 3, 2, 1));
        badStore();
        emit(encB(8, 3, 2, 4));
        badStore();
        emit(encB(8, 3, 2, 5));
        swCheck(3, 3);
        emit(encB(8, 3, 2, 6));
        swCheck(3, 3);
        emit(encB(8, 3, 2, 7));
        badStore();
        linkPc = wp * 4 + 4;
        emit(encJ(8, 7));
        badStore();
        swCheck(7, linkPc);
        basePc = wp * 4;
        emit(encU(0, 8, 'h17));
        emit(encI(12, 8, 0, 9, 'h67));
        badStore();
        swCheck(9, basePc + 8);
        // ecall, handler stores mepc and mcause
        addExpect(32'h580, wp * 4, 'hf);
        addExpect(32'h584, 11, 'hf);
        emit(32'h0000_0073);
        // pending irq is taken here as soon as mret sets MIE
        irqPc = wp * 4;
        badStore();
        addExpect(32'h588, 32'h8000_000b, 'hf);
        addExpect(32'h58c, irqPc, 'hf);
        addExpect(markerAddr, 3, 'hf);
        mainWords = wp;
        wp = 32'h200 / 4;
        emit(encI('h341, 0, 2, 5, 'h73));
        emit(encS('h180, 5, 10, 2));
        emit(encI('h342, 0, 2, 6, 'h73));
        emit(encS('h184, 6, 10, 2));
        emit(encI(4, 5, 0, 5, 'h13));
        emit(encI('h341, 5, 1, 0, 'h73));
        emit(32'h3020_0073);
        // external interrupt vector, base + 4 * 11
        wp = 32'h22c / 4;
        emit(encI('h342, 0, 2, 6, 'h73));
        emit(encS('h188, 6, 10, 2));
        emit(encI('h341, 0, 2, 5, 'h73));
        emit(encS('h18c, 5, 10, 2));
        emit(encS('h3f0, 3, 10, 2));
        emit(encJ(0, 0));
        limit = 4 * (mainWords + 13);
    endtask

    task automatic compareWord(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compareMask(string what, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mask mismatch");
        end
    endtask

    task automatic failRun(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run failed");
    endtask

    task automatic checkStore();
        if (storeIdx >= expCount) begin
            failRun("a store happened after every expected store was seen");
        end else begin
            compareWord("store address", memAddr, expAddr[storeIdx]);
            compareMask("store mask", memMask, expMask[storeIdx]);
            compareWord("store data", memWrData & laneBits(memMask),
                        expData[storeIdx] & laneBits(expMask[storeIdx]));
            storeIdx++;
            if (memAddr == markerAddr) begin
                if (storeIdx == expCount) begin
                    $display("=== PASS ===");
                    $finish;
                end else begin
                    failRun("end marker stored before all expected stores");
                end
            end
        end
    endtask

    // data memory and store monitor
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            failRun("timeout, the program never reached its end marker");
        end else if (!reset && memWE === 1'b1) begin
            for (int b = 0; b < 4; b++) begin
                if (memMask[b]) begin
                    dmem[memAddr[9:2]][8 * b +: 8] <= memWrData[8 * b +: 8];
                end
            end
            checkStore();
        end
    end

    initial begin
        reset     = 1'b1;
        irq       = 1'b0;
        cycles    = 0;
        storeIdx  = 0;
        lfsrState = 32'h06e1e028;
        irqDelay  = 4'd0;
        fillMemories();
        buildProgram();
        repeat (5) @(posedge clk);
        compareWord("pc after reset", pc, resetPc);
        reset <= 1'b0;
        // irq rises after a random delay and stays masked until mret sets MIE
        for (int b = 0; b < 4; b++) begin
            lfsrState = lfsrStep(lfsrState);
            irqDelay  = {irqDelay[2:0], lfsrState[0]};
        end
        repeat (irqDelay) @(posedge clk);
        irq <= 1'b1;
    end

endmodule
